//--- stackEngine.f
design/stackPkg.sv
design/stackIf.sv
design/cmdDispatch.sv
design/stackFrame.sv
design/resultCollect.sv
design/stackEngine.sv
verif/stackEngineTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stackEngineTb \
  -f stackEngine.f -o stackEngineSim || { echo "Build failed"; exit 1; }
./obj_dir/stackEngineSim > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with error"; exit 1; }
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && exit 1
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "No pass line in log"; exit 1; }
exit 0

//--- verif/stackEngineTb.sv
/* Reference model runs at command issue, so it relies on in-order completion per context
   Random commands and rspAck delays come from xorshift generators, each seeded with 71 */
`timescale 1ns/1ps
`default_nettype none

module stackEngineTb;

  localparam int NCTX     = 4;
  localparam int WIDTH    = 8;
  localparam int DEPTH    = 16;
  localparam int CW       = 2;
  localparam int IW       = $clog2(DEPTH + 1);
  localparam int randCmds = 200;
  localparam int numCmds  = 60 + randCmds;  // Directed tests plus the random run

  logic             clk = 1'b0;
  logic             reset;
  logic             cmdReq;
  logic             cmdAck;
  logic [CW-1:0]    cmdCtx;
  stackPkg::opE     cmdOp;
  logic [WIDTH-1:0] cmdData;
  logic [IW-1:0]    cmdPos;
  logic             rspReq;
  logic             rspAck;
  logic [CW-1:0]    rspCtx;
  stackPkg::statusE rspStatus;
  logic [WIDTH-1:0] rspValue;
  logic [IW-1:0]    rspIndex;

  // Reference model, one stack per context
  logic [WIDTH-1:0] modelMem [NCTX][DEPTH];
  int               modelIdx [NCTX];
  int               modelLim [NCTX];

  stackPkg::statusE expStatusQ [NCTX][$];
  logic [WIDTH-1:0] expValueQ  [NCTX][$];
  logic [IW-1:0]    expIndexQ  [NCTX][$];

  stackPkg::statusE expStatus;
  logic [WIDTH-1:0] expValue;
  logic [IW-1:0]    expIndex;
  logic             expValid = 1'b0;  // Head of queue loaded for the current response

  int          errors     = 0;
  int          issued     = 0;
  int          received   = 0;
  logic [31:0] rngState   = 32'd71;
  logic [31:0] delayState = 32'd71;  // Separate stream for the sink

  stackEngine #(.NCTX(NCTX), .WIDTH(WIDTH), .DEPTH(DEPTH)) u_dut (
    .clk       (clk),
    .reset     (reset),
    .cmdReq    (cmdReq),
    .cmdAck    (cmdAck),
    .cmdCtx    (cmdCtx),
    .cmdOp     (cmdOp),
    .cmdData   (cmdData),
    .cmdPos    (cmdPos),
    .rspReq    (rspReq),
    .rspAck    (rspAck),
    .rspCtx    (rspCtx),
    .rspStatus (rspStatus),
    .rspValue  (rspValue),
    .rspIndex  (rspIndex)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Applies one operation to the model and queues the response it implies
  task automatic predictAndQueue(input int ctx, input stackPkg::opE op,
                                 input int data, input int pos);
    int               idx;
    int               lim;
    stackPkg::statusE fault;
    logic             belowTop;
    stackPkg::statusE st;
    logic [WIDTH-1:0] val;
    idx      = modelIdx[ctx];
    lim      = modelLim[ctx];
    fault    = stackPkg::NONE;
    belowTop = 1'b0;
    case (op)
      stackPkg::PUSH: begin
        if (idx == DEPTH) fault = stackPkg::OVERFLOW;
        else begin
          modelMem[ctx][idx] = WIDTH'(data);
          idx++;
        end
      end
      stackPkg::POP: begin
        if (idx <= lim) fault = stackPkg::UNDERFLOW;
        else idx--;
      end
      stackPkg::REPLACE: begin
        if (idx <= lim) fault = stackPkg::UNDERFLOW;
        else modelMem[ctx][idx - 1] = WIDTH'(data);
      end
      stackPkg::CUT: begin
        if (pos > idx) fault = stackPkg::BADINDEX;
        else idx = pos;
      end
      stackPkg::SETLIMIT: begin
        if (pos > DEPTH) fault = stackPkg::BADINDEX;
        else lim = pos;
      end
      stackPkg::GET, stackPkg::SET: begin
        if (pos >= idx) fault = stackPkg::BADOFFSET;
        else begin
          belowTop = (pos != idx - 1);
          if (op == stackPkg::SET) modelMem[ctx][pos] = WIDTH'(data);
        end
      end
      default: begin
      end
    endcase
    if (fault != stackPkg::NONE) st = fault;
    else if (belowTop) st = stackPkg::NONE;
    else st = stackPkg::levelStatus(idx, lim, DEPTH);
    if (op == stackPkg::GET && fault == stackPkg::NONE) val = modelMem[ctx][pos];
    else if (idx == 0) val = '0;
    else val = modelMem[ctx][idx - 1];  // Entry just below the index
    modelIdx[ctx] = idx;
    modelLim[ctx] = lim;
    expStatusQ[ctx].push_back(st);
    expValueQ[ctx].push_back(val);
    expIndexQ[ctx].push_back(IW'(idx));
  endtask

  // Called on a falling edge, returns on a falling edge with cmdAck low
  task automatic sendCmd(input int ctx, input stackPkg::opE op, input int data, input int pos);
    cmdCtx  = CW'(ctx);
    cmdOp   = op;
    cmdData = WIDTH'(data);
    cmdPos  = IW'(pos);
    cmdReq  = 1'b1;
    predictAndQueue(ctx, op, data, pos);
    issued++;
    @(negedge clk);
    while (!cmdAck) @(negedge clk);
    cmdReq = 1'b0;
    @(negedge clk);
    while (cmdAck) @(negedge clk);
  endtask

  task automatic finishTest(input int num, input string name, input int startErrors);
    while (received != issued) @(negedge clk);
    $display("Test %0d %s: %0d errors", num, name, errors - startErrors);
  endtask

  // Sink side of the response port with random back-pressure
  initial begin : sinkLoop
    int c;
    int delay;
    rspAck = 1'b0;
    forever begin
      @(negedge clk);
      if (rspReq) begin
        c = int'(rspCtx);
        if (expStatusQ[c].size() == 0) begin
          $display("%0t: response on context %0d with no command outstanding", $time, c);
          errors++;
        end else begin
          expStatus = expStatusQ[c].pop_front();
          expValue  = expValueQ[c].pop_front();
          expIndex  = expIndexQ[c].pop_front();
          expValid  = 1'b1;
        end
        delayState = xorshift(delayState);
        delay      = int'(delayState % 6);
        repeat (delay) @(negedge clk);
        rspAck = 1'b1;
        while (rspReq) @(negedge clk);
        rspAck   = 1'b0;
        expValid = 1'b0;
        received++;
      end
    end
  end

  statusCheck: assert property (@(posedge clk) disable iff (reset)
    rspReq && expValid |-> rspStatus == expStatus)
    else begin
      $display("[FAIL] %0t rspStatus expected %s got %s", $time, expStatus.name(),
               rspStatus.name());
      errors++;
    end

  valueCheck: assert property (@(posedge clk) disable iff (reset)
    rspReq && expValid |-> rspValue == expValue)
    else begin
      $display("[FAIL] %0t rspValue expected %0h got %0h", $time, expValue, $sampled(rspValue));
      errors++;
    end

  indexCheck: assert property (@(posedge clk) disable iff (reset)
    rspReq && expValid |-> rspIndex == expIndex)
    else begin
      $display("[FAIL] %0t rspIndex expected %0d got %0d", $time, expIndex, $sampled(rspIndex));
      errors++;
    end

  initial begin : watchdog
    #(numCmds * 60 * 40);
    $display("Timeout: %0d commands issued, %0d responses received", issued, received);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : mainSeq
    int startErrors;
    stackPkg::opE op;
    reset   = 1'b1;
    cmdReq  = 1'b0;
    cmdCtx  = '0;
    cmdOp   = stackPkg::PEEK;
    cmdData = '0;
    cmdPos  = '0;
    for (int c = 0; c < NCTX; c++) begin
      modelIdx[c] = 0;
      modelLim[c] = 0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;

    startErrors = errors;
    for (int c = 0; c < NCTX; c++) sendCmd(c, stackPkg::PEEK, 0, 0);
    for (int k = 0; k < 3; k++)
      for (int c = 0; c < NCTX; c++) sendCmd(c, stackPkg::PUSH, c * 16 + k + 1, 0);
    finishTest(1, "reset and push", startErrors);

    startErrors = errors;
    sendCmd(1, stackPkg::CUT, 0, 0);
    for (int k = 0; k <= DEPTH; k++) sendCmd(1, stackPkg::PUSH, 8'h80 + k, 0);  // Last overflows
    finishTest(2, "full and overflow", startErrors);

    startErrors = errors;
    sendCmd(2, stackPkg::POP, 0, 0);
    sendCmd(2, stackPkg::REPLACE, 8'ha5, 0);
    sendCmd(2, stackPkg::PEEK, 0, 0);       // Top read back from storage
    sendCmd(2, stackPkg::POP, 0, 0);
    sendCmd(2, stackPkg::POP, 0, 0);
    sendCmd(2, stackPkg::POP, 0, 0);
    sendCmd(2, stackPkg::REPLACE, 8'h11, 0);
    for (int k = 0; k < 4; k++) sendCmd(2, stackPkg::PUSH, 8'h40 + k, 0);
    sendCmd(2, stackPkg::SETLIMIT, 0, 4);   // Limit at the index
    sendCmd(2, stackPkg::SETLIMIT, 0, 6);   // Limit above the index
    sendCmd(2, stackPkg::POP, 0, 0);
    sendCmd(2, stackPkg::SETLIMIT, 0, DEPTH + 4);
    sendCmd(2, stackPkg::SETLIMIT, 0, 2);
    sendCmd(2, stackPkg::POP, 0, 0);
    finishTest(3, "pop, replace and limit", startErrors);

    startErrors = errors;
    sendCmd(3, stackPkg::GET, 0, 0);
    sendCmd(3, stackPkg::GET, 0, 2);
    sendCmd(3, stackPkg::GET, 0, 3);
    sendCmd(3, stackPkg::SET, 8'h5a, 1);
    sendCmd(3, stackPkg::GET, 0, 1);
    sendCmd(3, stackPkg::SET, 8'h77, 5);
    sendCmd(3, stackPkg::CUT, 0, 1);
    sendCmd(3, stackPkg::CUT, 0, 4);
    sendCmd(3, stackPkg::PEEK, 0, 0);
    finishTest(4, "get, set and cut", startErrors);

    startErrors = errors;
    for (int n = 0; n < randCmds; n++) begin
      rngState = xorshift(rngState);
      op       = stackPkg::opE'(rngState[6:4]);
      sendCmd(int'(rngState[1:0]), op, int'(rngState[15:8]), int'(rngState[31:16] % (DEPTH + 2)));
    end
    finishTest(5, "random interleaved", startErrors);

    $display("Tests 5, commands %0d, responses %0d, errors %0d", issued, received, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/stackEngine.sv
/* Both ports are four-phase req/ack; order is kept per context only
   Responses from different contexts may return in any order */
`timescale 1ns/1ps
`default_nettype none

module stackEngine #(
  parameter int NCTX  = 4,
  parameter int WIDTH = 8,
  parameter int DEPTH = 16,
  localparam int CW   = (NCTX > 1) ? $clog2(NCTX) : 1,
  localparam int IW   = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cmdReq,
  output logic             cmdAck,
  input  logic [CW-1:0]    cmdCtx,
  input  stackPkg::opE     cmdOp,
  input  logic [WIDTH-1:0] cmdData,
  input  logic [IW-1:0]    cmdPos,
  output logic             rspReq,
  input  logic             rspAck,
  output logic [CW-1:0]    rspCtx,
  output stackPkg::statusE rspStatus,
  output logic [WIDTH-1:0] rspValue,
  output logic [IW-1:0]    rspIndex
);

  stackIf #(.WIDTH(WIDTH), .DEPTH(DEPTH)) links [NCTX] ();  // One per context

  cmdDispatch #(.NCTX(NCTX), .WIDTH(WIDTH), .DEPTH(DEPTH)) uDispatch (
    .clk     (clk),
    .reset   (reset),
    .cmdReq  (cmdReq),
    .cmdAck  (cmdAck),
    .cmdCtx  (cmdCtx),
    .cmdOp   (cmdOp),
    .cmdData (cmdData),
    .cmdPos  (cmdPos),
    .frames  (links)
  );

  for (genvar i = 0; i < NCTX; i++) begin : gFrame
    stackFrame #(.WIDTH(WIDTH), .DEPTH(DEPTH)) uFrame (
      .clk   (clk),
      .reset (reset),
      .link  (links[i])
    );
  end

  resultCollect #(.NCTX(NCTX), .WIDTH(WIDTH), .DEPTH(DEPTH)) uCollect (
    .clk       (clk),
    .reset     (reset),
    .frames    (links),
    .rspReq    (rspReq),
    .rspAck    (rspAck),
    .rspCtx    (rspCtx),
    .rspStatus (rspStatus),
    .rspValue  (rspValue),
    .rspIndex  (rspIndex)
  );

endmodule

`default_nettype wire

//--- design/resultCollect.sv
/* Round-robin over done frames, one response in flight at a time
   A result stays in its frame until the sink has acknowledged it */
`timescale 1ns/1ps
`default_nettype none

module resultCollect #(
  parameter int NCTX  = 4,
  parameter int WIDTH = 8,
  parameter int DEPTH = 16,
  localparam int CW   = (NCTX > 1) ? $clog2(NCTX) : 1,
  localparam int IW   = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             reset,
  stackIf.collect          frames [NCTX],
  output logic             rspReq,
  input  logic             rspAck,
  output logic [CW-1:0]    rspCtx,
  output stackPkg::statusE rspStatus,
  output logic [WIDTH-1:0] rspValue,
  output logic [IW-1:0]    rspIndex
);

  logic [NCTX-1:0]  doneV;
  logic [NCTX-1:0]  takeR;
  stackPkg::statusE statusA [NCTX];
  logic [WIDTH-1:0] valueA  [NCTX];
  logic [IW-1:0]    indexA  [NCTX];

  logic [CW-1:0] ptr;        // First context to look at
  logic [CW-1:0] pick;
  logic          found;
  logic          loaded;     // Result latched, rspReq next cycle
  logic          releasing;  // Waiting for rspAck to fall
  logic          idle;

  for (genvar i = 0; i < NCTX; i++) begin : gLink
    assign doneV[i]      = frames[i].done;
    assign statusA[i]    = frames[i].status;
    assign valueA[i]     = frames[i].value;
    assign indexA[i]     = frames[i].index;
    assign frames[i].take = takeR[i];
  end

  always_comb begin
    int idx;
    found = 1'b0;
    pick  = ptr;
    // Walk backwards so the frame nearest to ptr wins
    for (int k = NCTX - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NCTX;
      if (doneV[idx]) begin
        found = 1'b1;
        pick  = CW'(idx);
      end
    end
  end

  assign idle = !loaded && !rspReq && !releasing;

  always_ff @(posedge clk) begin
    if (reset) begin
      takeR     <= '0;
      loaded    <= 1'b0;
      rspReq    <= 1'b0;
      releasing <= 1'b0;
      ptr       <= '0;
    end else begin
      takeR <= '0;
      if (idle && found) begin
        loaded <= 1'b1;
        ptr    <= (pick == CW'(NCTX - 1)) ? '0 : pick + 1'b1;
      end
      if (loaded) begin
        loaded <= 1'b0;
        rspReq <= 1'b1;
      end
      if (rspReq && rspAck) begin
        rspReq        <= 1'b0;
        releasing     <= 1'b1;
        takeR[rspCtx] <= 1'b1;  // Frame drops done on the next edge
      end
      if (releasing && !rspAck) begin
        releasing <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (idle && found) begin
      rspCtx    <= pick;
      rspStatus <= statusA[pick];
      rspValue  <= valueA[pick];
      rspIndex  <= indexA[pick];
    end
  end

  rspStable: assert property (@(posedge clk) disable iff (reset)
    rspReq && $past(rspReq) |-> $stable({rspCtx, rspStatus, rspValue, rspIndex}))
    else $error("response fields changed while rspReq high");

endmodule

`default_nettype wire

//--- design/stackFrame.sv
/* Executes one operation per req and holds the result until the collector takes it
   DEPTH entries in a register array; positions are 0 at the bottom */
`timescale 1ns/1ps
`default_nettype none

module stackFrame #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16,
  localparam int IW   = $clog2(DEPTH + 1),
  localparam int AW   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input logic   clk,
  input logic   reset,
  stackIf.frame link
);

  logic [WIDTH-1:0] mem [DEPTH];

  logic [IW-1:0]    indexR;  // Number of live entries
  logic [IW-1:0]    limitR;  // Underflow limit
  logic             ackR;
  logic             doneR;
  stackPkg::statusE statusR;
  logic [WIDTH-1:0] valueR;

  logic             start;
  logic [IW-1:0]    nIndex;
  logic [IW-1:0]    nLimit;
  stackPkg::statusE nStatus;
  stackPkg::statusE fault;
  logic [WIDTH-1:0] nValue;
  logic             we;
  logic [IW-1:0]    wAddr;
  logic             rdGet;
  logic             belowTop;  // GET or SET that leaves the top alone

  // New request only when the previous one is fully closed and claimed
  assign start = link.req && !ackR && !doneR;

  always_comb begin
    nIndex   = indexR;
    nLimit   = limitR;
    fault    = stackPkg::NONE;
    we       = 1'b0;
    wAddr    = indexR;
    rdGet    = 1'b0;
    belowTop = 1'b0;

    case (link.op)
      stackPkg::PUSH: begin
        if (indexR == DEPTH) begin
          fault = stackPkg::OVERFLOW;
        end else begin
          we     = 1'b1;
          wAddr  = indexR;
          nIndex = indexR + 1'b1;
        end
      end
      stackPkg::POP: begin
        if (indexR <= limitR) begin
          fault = stackPkg::UNDERFLOW;
        end else begin
          nIndex = indexR - 1'b1;
        end
      end
      stackPkg::REPLACE: begin
        if (indexR <= limitR) begin
          fault = stackPkg::UNDERFLOW;
        end else begin
          we    = 1'b1;
          wAddr = indexR - 1'b1;
        end
      end
      stackPkg::CUT: begin
        if (link.pos > indexR) begin
          fault = stackPkg::BADINDEX;  // Only moves down
        end else begin
          nIndex = link.pos;
        end
      end
      stackPkg::SETLIMIT: begin
        if (link.pos > DEPTH) begin
          fault = stackPkg::BADINDEX;
        end else begin
          nLimit = link.pos;
        end
      end
      stackPkg::GET: begin
        if (link.pos >= indexR) begin
          fault = stackPkg::BADOFFSET;
        end else begin
          rdGet    = 1'b1;
          belowTop = (link.pos != indexR - 1'b1);
        end
      end
      stackPkg::SET: begin
        if (link.pos >= indexR) begin
          fault = stackPkg::BADOFFSET;
        end else begin
          we       = 1'b1;
          wAddr    = link.pos;
          belowTop = (link.pos != indexR - 1'b1);
        end
      end
      default: begin
        // PEEK changes nothing
      end
    endcase

    if (fault != stackPkg::NONE) begin
      nStatus = fault;
    end else if (belowTop) begin
      nStatus = stackPkg::NONE;
    end else begin
      nStatus = stackPkg::levelStatus(nIndex, nLimit, DEPTH);
    end

    // Entry below the new index, bypassing a write that lands there
    if (rdGet) begin
      nValue = mem[link.pos[AW-1:0]];
    end else if (nIndex == '0) begin
      nValue = '0;
    end else if (we && wAddr == nIndex - 1'b1) begin
      nValue = link.data;
    end else begin
      nValue = mem[AW'(nIndex - 1'b1)];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ackR    <= 1'b0;
      doneR   <= 1'b0;
      indexR  <= '0;
      limitR  <= '0;
      statusR <= stackPkg::EMPTY;
    end else if (start) begin
      ackR    <= 1'b1;
      doneR   <= 1'b1;
      indexR  <= nIndex;
      limitR  <= nLimit;
      statusR <= nStatus;
    end else begin
      if (ackR && !link.req) begin
        ackR <= 1'b0;
      end
      if (link.take) begin
        doneR <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      valueR <= nValue;
    end
    if (start && we) begin
      mem[wAddr[AW-1:0]] <= link.data;
    end
  end

  assign link.ack    = ackR;
  assign link.done   = doneR;
  assign link.status = statusR;
  assign link.value  = valueR;
  assign link.index  = indexR;

  indexBound: assert property (@(posedge clk) disable iff (reset)
    indexR <= DEPTH)
    else $error("index %0d above DEPTH", indexR);

  // Dispatcher holds req until it sees ack
  ackOnReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ackR) |-> link.req)
    else $error("ack raised without req");

endmodule

`default_nettype wire

//--- design/cmdDispatch.sv
/* Single command register: a command to a busy context stalls every later command
   cmdCtx must name an existing context when NCTX is not a power of two */
`timescale 1ns/1ps
`default_nettype none

module cmdDispatch #(
  parameter int NCTX  = 4,
  parameter int WIDTH = 8,
  parameter int DEPTH = 16,
  localparam int CW   = (NCTX > 1) ? $clog2(NCTX) : 1,
  localparam int IW   = $clog2(DEPTH + 1)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             cmdReq,
  output logic             cmdAck,
  input  logic [CW-1:0]    cmdCtx,
  input  stackPkg::opE     cmdOp,
  input  logic [WIDTH-1:0] cmdData,
  input  logic [IW-1:0]    cmdPos,
  stackIf.dispatch         frames [NCTX]
);

  logic             pending;  // Command register holds a command
  logic [CW-1:0]    ctxR;
  stackPkg::opE     opR;
  logic [WIDTH-1:0] dataR;
  logic [IW-1:0]    posR;

  logic [NCTX-1:0]  reqR;
  logic [NCTX-1:0]  ackV;
  logic [NCTX-1:0]  doneV;
  stackPkg::opE     frameOp   [NCTX];
  logic [WIDTH-1:0] frameData [NCTX];
  logic [IW-1:0]    framePos  [NCTX];

  logic accept;
  logic launch;

  assign accept = cmdReq && !cmdAck && !pending;
  // Target frame fully idle, so per-context order is kept
  assign launch = pending && !reqR[ctxR] && !ackV[ctxR] && !doneV[ctxR];

  always_ff @(posedge clk) begin
    if (reset) begin
      cmdAck  <= 1'b0;
      pending <= 1'b0;
      reqR    <= '0;
    end else begin
      if (accept) begin
        cmdAck  <= 1'b1;
        pending <= 1'b1;
      end else if (cmdAck && !cmdReq) begin
        cmdAck <= 1'b0;  // Source released, close the handshake
      end
      if (launch) begin
        pending <= 1'b0;
      end
      for (int i = 0; i < NCTX; i++) begin
        if (launch && ctxR == CW'(i)) begin
          reqR[i] <= 1'b1;
        end else if (ackV[i]) begin
          reqR[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ctxR  <= cmdCtx;
      opR   <= cmdOp;
      dataR <= cmdData;
      posR  <= cmdPos;
    end
    if (launch) begin
      frameOp[ctxR]   <= opR;
      frameData[ctxR] <= dataR;
      framePos[ctxR]  <= posR;
    end
  end

  for (genvar i = 0; i < NCTX; i++) begin : gLink
    assign frames[i].req  = reqR[i];
    assign frames[i].op   = frameOp[i];
    assign frames[i].data = frameData[i];
    assign frames[i].pos  = framePos[i];
    assign ackV[i]        = frames[i].ack;
    assign doneV[i]       = frames[i].done;

    // A frame must have handed its last result to the collector first
    reqOnDone: assert property (@(posedge clk) disable iff (reset)
      $rose(reqR[i]) |-> !doneV[i])
      else $error("req raised on context %0d while done is high", i);
  end

endmodule

`default_nettype wire

//--- design/stackIf.sv
/* One link per context. The dispatcher also watches done, so it never starts a
   frame that still holds an unclaimed result */
`timescale 1ns/1ps
`default_nettype none

interface stackIf #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16
);
  localparam int IW = $clog2(DEPTH + 1);

  // Command side
  logic             req;
  stackPkg::opE     op;
  logic [WIDTH-1:0] data;
  logic [IW-1:0]    pos;

  // Result side, held while done is high
  logic             ack;
  logic             done;
  stackPkg::statusE status;
  logic [WIDTH-1:0] value;
  logic [IW-1:0]    index;

  logic             take;  // One-cycle claim from the collector

  modport dispatch (output req, op, data, pos, input ack, done);

  modport frame (
    input  req, op, data, pos, take,
    output ack, done, status, value, index
  );

  modport collect (input done, status, value, index, output take);

endinterface

`default_nettype wire

//--- design/stackPkg.sv
/* levelStatus takes plain unsigned values, so callers of any index width zero-extend into it
   Opcode slot 5 is SETLIMIT; the cut-and-push operation is not supported */
`default_nettype none

package stackPkg;

  typedef enum logic [2:0] {
    PEEK     = 3'd0,  // Report top of stack
    PUSH     = 3'd1,
    POP      = 3'd2,  // Exactly one entry
    REPLACE  = 3'd3,
    CUT      = 3'd4,  // Index down to pos
    SETLIMIT = 3'd5,  // Underflow limit from pos
    GET      = 3'd6,
    SET      = 3'd7
  } opE;

  typedef enum logic [2:0] {
    NONE      = 3'd0,
    EMPTY     = 3'd1,
    FULL      = 3'd2,
    UNDERFLOW = 3'd3,
    OVERFLOW  = 3'd4,
    BADINDEX  = 3'd5,
    BADOFFSET = 3'd6
  } statusE;

  // Level reported after a successful operation, checked in this order
  function automatic statusE levelStatus(
    input int unsigned index,
    input int unsigned limit,
    input int unsigned depth
  );
    if (index == depth) begin
      return FULL;
    end else if (index == limit) begin
      return EMPTY;
    end else if (index < limit) begin
      return UNDERFLOW;  // Limit was raised above the current top
    end
    return NONE;
  endfunction

endpackage

`default_nettype wire
